/* verilog/conv_defs.svh */
`ifndef CONV_DEFS_SVH
`define CONV_DEFS_SVH

// Frame geometry
`define CONV_IMG_W       8
`define CONV_IMG_H       8

// Kernel and filter bank
`define CONV_K           3
`define CONV_TAPS        9
`define CONV_NUM_FILT    2

// Data widths
`define CONV_PIX_W       8
`define CONV_COEF_W      16
`define CONV_FEAT_W      16

// Pipeline shape, window register excluded
`define CONV_TREE_STAGES 4
`define CONV_LATENCY     6

// Control bus
`define CONV_WB_AW       8
`define CONV_WB_DW       16

`endif

/* verilog/conv_data_pkg.sv */
`default_nettype none

`include "conv_defs.svh"

package conv_data_pkg;

    // Scalar types along the datapath
    typedef logic        [`CONV_PIX_W-1:0]  pixel_t;
    typedef logic signed [7:0]              weight_t;
    typedef logic signed [`CONV_COEF_W-1:0] bias_t;
    // 9-bit zero-extended pixel times 8-bit weight
    typedef logic signed [16:0]             prod_t;
    // Nine products plus bias with headroom
    typedef logic signed [21:0]             sum_t;
    typedef logic signed [`CONV_FEAT_W-1:0] feat_t;

    // Index 0 is the top-left pixel, row-major
    typedef struct packed {
        pixel_t [`CONV_TAPS-1:0] pix;
    } window_t;

    // Weight w[f][t] is tap t of filter f
    typedef struct packed {
        weight_t [`CONV_NUM_FILT-1:0][`CONV_TAPS-1:0] w;
        bias_t   [`CONV_NUM_FILT-1:0]                 b;
    } coef_t;

    typedef struct packed {
        feat_t [`CONV_NUM_FILT-1:0] f;
    } feat_vec_t;

endpackage

`default_nettype wire

/* verilog/conv_bus_pkg.sv */
`default_nettype none

`include "conv_defs.svh"

package conv_bus_pkg;

    // Master to slave, classic cycle
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`CONV_WB_AW-1:0] adr;
        logic [`CONV_WB_DW-1:0] dat;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic                   ack;
        logic [`CONV_WB_DW-1:0] dat;
    } wb_rsp_t;

    // Region select from the top two address bits
    // Code 3 is unmapped and reads zero
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_BIAS   = 2'd1,
        REG_WEIGHT = 2'd2
    } reg_region_e;

endpackage

`default_nettype wire

/* verilog/conv_coef_regs.sv */
`default_nettype none

`include "conv_defs.svh"

module conv_coef_regs (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire conv_bus_pkg::wb_req_t i_wb,
    output conv_bus_pkg::wb_rsp_t      o_wb,
    output logic                       o_enable,
    output conv_data_pkg::coef_t       o_coef
);
    import conv_bus_pkg::*;
    import conv_data_pkg::*;

    reg_region_e             region;
    logic [`CONV_WB_AW-3:0]  index;
    logic                    req;
    logic                    ack_q;
    logic [`CONV_WB_DW-1:0]  rdat_d;
    logic [`CONV_WB_DW-1:0]  rdat_q;
    logic                    enable_q;
    coef_t                   coef_q;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////
    always_comb begin
        region = reg_region_e'(i_wb.adr[`CONV_WB_AW-1 -: 2]);
        index  = i_wb.adr[`CONV_WB_AW-3:0];
        // New request only, so ack stays one cycle while stb is held
        req    = i_wb.cyc & i_wb.stb & ~ack_q;
    end

    // Read mux, out-of-range indexes fall through to zero
    always_comb begin
        rdat_d = '0;
        case (region)
            REG_CTRL: begin
                if (index == 0) begin
                    rdat_d = `CONV_WB_DW'(enable_q);
                end
            end
            REG_BIAS: begin
                for (int f = 0; f < `CONV_NUM_FILT; f++) begin
                    if (index == f) begin
                        rdat_d = `CONV_WB_DW'(coef_q.b[f]);
                    end
                end
            end
            REG_WEIGHT: begin
                for (int f = 0; f < `CONV_NUM_FILT; f++) begin
                    for (int t = 0; t < `CONV_TAPS; t++) begin
                        // Sign-extended on the way out
                        if (index == f * `CONV_TAPS + t) begin
                            rdat_d = `CONV_WB_DW'(coef_q.w[f][t]);
                        end
                    end
                end
            end
            default: rdat_d = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Register file and ack
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ack_q    <= 1'b0;
            enable_q <= 1'b0;
            coef_q   <= '0;
        end else begin
            ack_q <= req;
            // Write lands on the edge that raises ack
            if (req && i_wb.we) begin
                case (region)
                    REG_CTRL: begin
                        if (index == 0) begin
                            enable_q <= i_wb.dat[0];
                        end
                    end
                    REG_BIAS: begin
                        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
                            if (index == f) begin
                                coef_q.b[f] <= bias_t'(i_wb.dat);
                            end
                        end
                    end
                    REG_WEIGHT: begin
                        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
                            for (int t = 0; t < `CONV_TAPS; t++) begin
                                // Low byte only
                                if (index == f * `CONV_TAPS + t) begin
                                    coef_q.w[f][t] <= weight_t'(i_wb.dat[7:0]);
                                end
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // Read data captured with the request
    always_ff @(posedge i_clk) begin
        if (req) begin
            rdat_q <= rdat_d;
        end
    end

    always_comb begin
        o_wb.ack = ack_q;
        o_wb.dat = rdat_q;
        o_enable = enable_q;
        o_coef   = coef_q;
    end

endmodule

`default_nettype wire

/* verilog/conv_window_gen.sv */
`default_nettype none

`include "conv_defs.svh"

module conv_window_gen (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire logic                  i_enable,
    input  wire logic                  i_pix_valid,
    input  wire conv_data_pkg::pixel_t i_pix,
    output logic                       o_pix_ready,
    output logic                       o_win_valid,
    output conv_data_pkg::window_t     o_win
);
    import conv_data_pkg::*;

    localparam int COL_W = $clog2(`CONV_IMG_W);
    localparam int ROW_W = $clog2(`CONV_IMG_H);

    typedef enum logic {
        WIN_IDLE,
        WIN_RUN
    } win_state_e;

    win_state_e        state_q;
    logic [COL_W-1:0]  col_q;
    logic [ROW_W-1:0]  row_q;
    logic [COL_W-1:0]  col_cur;
    logic [ROW_W-1:0]  row_cur;
    logic              accept;
    logic              win_done;
    logic              win_valid_q;
    window_t           win_q;

    // Previous rows, entry 0 is the oldest
    pixel_t line_mem [`CONV_K-1][`CONV_IMG_W];
    // Column entering the window, top row first
    pixel_t [`CONV_K-1:0] col_in;

    // No back-pressure beyond the enable bit
    assign o_pix_ready = i_enable;
    assign accept      = i_pix_valid & i_enable;

    //////////////////////////////////////////////////
    // Raster position
    //////////////////////////////////////////////////
    always_comb begin
        // While idle the counters count as zero
        // Covers a pixel taken on the first enabled cycle
        col_cur  = (state_q == WIN_IDLE) ? '0 : col_q;
        row_cur  = (state_q == WIN_IDLE) ? '0 : row_q;
        win_done = accept && (col_cur >= COL_W'(`CONV_K - 1))
                          && (row_cur >= ROW_W'(`CONV_K - 1));
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= WIN_IDLE;
            col_q   <= '0;
            row_q   <= '0;
        end else begin
            state_q <= i_enable ? WIN_RUN : WIN_IDLE;
            if (accept) begin
                if (col_cur == COL_W'(`CONV_IMG_W - 1)) begin
                    col_q <= '0;
                    // Wrap straight into the next frame
                    row_q <= (row_cur == ROW_W'(`CONV_IMG_H - 1)) ? '0 : row_cur + 1'b1;
                end else begin
                    col_q <= col_cur + 1'b1;
                    row_q <= row_cur;
                end
            end else if (state_q == WIN_IDLE) begin
                // Partial frame dropped
                col_q <= '0;
                row_q <= '0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Line memories and window register
    //////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < `CONV_K - 1; i++) begin
            col_in[i] = line_mem[i][col_cur];
        end
        col_in[`CONV_K-1] = i_pix;
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            // Each row moves up one memory
            for (int i = 0; i < `CONV_K - 2; i++) begin
                line_mem[i][col_cur] <= line_mem[i + 1][col_cur];
            end
            line_mem[`CONV_K-2][col_cur] <= i_pix;
            // Shift window left by one column
            for (int i = 0; i < `CONV_K; i++) begin
                for (int j = 0; j < `CONV_K - 1; j++) begin
                    win_q.pix[i * `CONV_K + j] <= win_q.pix[i * `CONV_K + j + 1];
                end
                win_q.pix[i * `CONV_K + `CONV_K - 1] <= col_in[i];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            win_valid_q <= 1'b0;
        end else begin
            win_valid_q <= win_done;
        end
    end

    assign o_win_valid = win_valid_q;
    assign o_win       = win_q;

endmodule

`default_nettype wire

/* verilog/conv_mac_array.sv */
`default_nettype none

`include "conv_defs.svh"

module conv_mac_array (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst,
    input  wire logic                   i_win_valid,
    input  wire conv_data_pkg::window_t i_win,
    input  wire conv_data_pkg::coef_t   i_coef,
    output logic                        o_feat_valid,
    output conv_data_pkg::feat_vec_t    o_feat
);
    import conv_data_pkg::*;

    localparam sum_t FEAT_MAX = sum_t'(2 ** (`CONV_FEAT_W - 1) - 1);
    localparam sum_t FEAT_MIN = -sum_t'(2 ** (`CONV_FEAT_W - 1));

    // Operand count entering tree level l
    function automatic int tree_width(input int l);
        int n;
        n = `CONV_TAPS;
        for (int k = 0; k < l; k++) begin
            n = (n + 1) / 2;
        end
        return n;
    endfunction

    prod_t                    prod_d [`CONV_NUM_FILT][`CONV_TAPS];
    // Level 0 holds products, last level holds the full sum in entry 0
    sum_t                     tree_q [`CONV_NUM_FILT][`CONV_TREE_STAGES+1][`CONV_TAPS];
    sum_t                     biased [`CONV_NUM_FILT];
    logic [`CONV_LATENCY-1:0] vld_q;
    feat_vec_t                feat_q;

    //////////////////////////////////////////////////
    // Multiply and adder tree
    //////////////////////////////////////////////////
    always_comb begin
        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                // Unsigned pixel, signed weight
                prod_d[f][t] = $signed({1'b0, i_win.pix[t]}) * i_coef.w[f][t];
            end
            biased[f] = tree_q[f][`CONV_TREE_STAGES][0] + sum_t'(i_coef.b[f]);
        end
    end

    always_ff @(posedge i_clk) begin
        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                tree_q[f][0][t] <= sum_t'(prod_d[f][t]);
            end
            // Pairwise sums, odd operand passes through
            for (int l = 0; l < `CONV_TREE_STAGES; l++) begin
                for (int i = 0; i < `CONV_TAPS / 2; i++) begin
                    if (2 * i + 1 < tree_width(l)) begin
                        tree_q[f][l + 1][i] <= tree_q[f][l][2 * i] + tree_q[f][l][2 * i + 1];
                    end
                end
                if (tree_width(l) % 2 == 1) begin
                    tree_q[f][l + 1][tree_width(l) / 2] <= tree_q[f][l][tree_width(l) - 1];
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Bias, saturation and valid pipe
    //////////////////////////////////////////////////
    always_ff @(posedge i_clk) begin
        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
            if (biased[f] > FEAT_MAX) begin
                feat_q.f[f] <= feat_t'(FEAT_MAX);
            end else if (biased[f] < FEAT_MIN) begin
                feat_q.f[f] <= feat_t'(FEAT_MIN);
            end else begin
                feat_q.f[f] <= feat_t'(biased[f]);
            end
        end
    end

    // One bit per stage: multiply, tree levels, output
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`CONV_LATENCY-2:0], i_win_valid};
        end
    end

    assign o_feat_valid = vld_q[`CONV_LATENCY-1];
    assign o_feat       = feat_q;

endmodule

`default_nettype wire

/* verilog/conv_top.sv */
`default_nettype none

module conv_top (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst,
    input  wire conv_bus_pkg::wb_req_t i_wb,
    output conv_bus_pkg::wb_rsp_t      o_wb,
    input  wire logic                  i_pix_valid,
    input  wire conv_data_pkg::pixel_t i_pix,
    output logic                       o_pix_ready,
    output logic                       o_feat_valid,
    output conv_data_pkg::feat_vec_t   o_feat
);
    import conv_data_pkg::*;

    logic    enable;
    coef_t   coef;
    logic    win_valid;
    window_t win;

    //////////////////////////////////////////////////
    // Control port
    //////////////////////////////////////////////////
    conv_coef_regs u_coef_regs (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_wb     (i_wb),
        .o_wb     (o_wb),
        .o_enable (enable),
        .o_coef   (coef)
    );

    // Raster stream to 3x3 windows
    conv_window_gen u_window_gen (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_enable    (enable),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_pix_ready (o_pix_ready),
        .o_win_valid (win_valid),
        .o_win       (win)
    );

    // Windows to one feature per filter
    conv_mac_array u_mac_array (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_win_valid  (win_valid),
        .i_win        (win),
        .i_coef       (coef),
        .o_feat_valid (o_feat_valid),
        .o_feat       (o_feat)
    );

endmodule

`default_nettype wire

/* dv/conv_sva.sv */
`default_nettype none

`include "conv_defs.svh"

module conv_sva (
    input wire logic                  i_clk,
    input wire logic                  i_rst,
    input wire conv_bus_pkg::wb_req_t i_wb_req,
    input wire conv_bus_pkg::wb_rsp_t i_wb_rsp,
    input wire logic                  i_pix_ready,
    input wire logic                  i_feat_valid
);

    // Window register plus the MAC pipeline
    localparam int DRAIN_CYCLES = `CONV_LATENCY + 1;

    // Consecutive cycles with the pixel input closed, saturating
    logic [3:0] closed_cnt;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            closed_cnt <= '0;
        end else if (i_pix_ready) begin
            closed_cnt <= '0;
        end else if (closed_cnt != 4'hf) begin
            closed_cnt <= closed_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Wishbone classic slave
    //////////////////////////////////////////////////
    ack_needs_stb: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_rsp.ack |-> i_wb_req.stb)
        else $error("Wishbone ack without stb");

    // Single-cycle ack
    ack_one_cycle: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_rsp.ack |=> !i_wb_rsp.ack)
        else $error("Wishbone ack held for two cycles");

    //////////////////////////////////////////////////
    // Stream side
    //////////////////////////////////////////////////
    // Nothing left in flight once the input stayed closed long enough
    drained_when_closed: assert property (@(posedge i_clk) disable iff (i_rst)
        (closed_cnt >= 4'(DRAIN_CYCLES)) |-> !i_feat_valid)
        else $error("Feature output long after the pixel input closed");

endmodule

bind conv_top conv_sva u_sva (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_wb_req     (i_wb),
    .i_wb_rsp     (o_wb),
    .i_pix_ready  (o_pix_ready),
    .i_feat_valid (o_feat_valid)
);

`default_nettype wire

/* dv/conv_checker.sv */
`default_nettype none

`include "conv_defs.svh"

module conv_checker (
    input wire logic                     i_clk,
    input wire logic                     i_rst,
    input wire logic                     i_pix_valid,
    input wire conv_data_pkg::pixel_t    i_pix,
    input wire logic                     i_pix_ready,
    input wire logic                     i_feat_valid,
    input wire conv_data_pkg::feat_vec_t i_feat
);
    import conv_data_pkg::*;

    // Sampling cycles from the accepted pixel to its output
    localparam int OUT_DELAY = `CONV_LATENCY + 1;

    // Coefficient copy, loaded by the testbench
    int wgt [`CONV_NUM_FILT][`CONV_TAPS];
    int bias [`CONV_NUM_FILT];

    // Pixels of the current frame, [row][col]
    int frame [`CONV_IMG_H][`CONV_IMG_W];
    int row;
    int col;
    int cyc;
    bit seen_enable;

    // Expected outputs in arrival order
    feat_vec_t exp_feat_q [$];
    int        exp_due_q [$];
    int        exp_pos_q [$];

    int err_cnt;
    int checked_cnt;
    int pending_cnt;

    // Scratch for the popped entry
    feat_vec_t exp_feat;
    int        exp_due;
    int        exp_pos;

    task automatic set_weight(input int f, input int t, input int w);
        wgt[f][t] = w;
    endtask

    task automatic set_bias(input int f, input int b);
        bias[f] = b;
    endtask

    function automatic int saturate(input int v);
        int hi;
        int lo;
        hi = (1 << (`CONV_FEAT_W - 1)) - 1;
        lo = -(1 << (`CONV_FEAT_W - 1));
        if (v > hi) begin
            return hi;
        end
        if (v < lo) begin
            return lo;
        end
        return v;
    endfunction

    // Window whose bottom-right pixel sits at row r, column c
    function automatic feat_vec_t model_window(input int r, input int c);
        feat_vec_t v;
        int        acc;
        int        top;
        int        left;
        top  = r - `CONV_K + 1;
        left = c - `CONV_K + 1;
        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
            acc = bias[f];
            for (int dr = 0; dr < `CONV_K; dr++) begin
                for (int dc = 0; dc < `CONV_K; dc++) begin
                    acc += wgt[f][dr * `CONV_K + dc] * frame[top + dr][left + dc];
                end
            end
            v.f[f] = feat_t'(saturate(acc));
        end
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Sampling at the falling edge
    //////////////////////////////////////////////////
    always @(negedge i_clk) begin
        if (i_rst) begin
            row = 0;
            col = 0;
        end else begin
            cyc++;
            // Due window that never showed up
            if (exp_due_q.size() > 0 && exp_due_q[0] < cyc) begin
                err_cnt++;
                $display("Error at time %0t: no output for the window ending at row %0d col %0d",
                         $time, exp_pos_q[0] / `CONV_IMG_W, exp_pos_q[0] % `CONV_IMG_W);
                exp_feat = exp_feat_q.pop_front();
                exp_due  = exp_due_q.pop_front();
                exp_pos  = exp_pos_q.pop_front();
            end
            if (i_feat_valid) begin
                if (!seen_enable) begin
                    err_cnt++;
                    $display("Error at time %0t: output while the input was never enabled", $time);
                end
                if (exp_due_q.size() == 0) begin
                    err_cnt++;
                    $display("Error at time %0t: output with no window pending", $time);
                end else begin
                    exp_feat = exp_feat_q.pop_front();
                    exp_due  = exp_due_q.pop_front();
                    exp_pos  = exp_pos_q.pop_front();
                    checked_cnt++;
                    if (cyc != exp_due) begin
                        err_cnt++;
                        $display("MISMATCH at time %0t: window %0d came at cycle %0d, due %0d",
                                 $time, exp_pos, cyc, exp_due);
                    end
                    for (int f = 0; f < `CONV_NUM_FILT; f++) begin
                        if (i_feat.f[f] !== exp_feat.f[f]) begin
                            err_cnt++;
                            $display("MISMATCH at time %0t: filter %0d row %0d col %0d got %0d exp %0d",
                                     $time, f, exp_pos / `CONV_IMG_W, exp_pos % `CONV_IMG_W,
                                     i_feat.f[f], exp_feat.f[f]);
                        end
                    end
                end
            end
            // Closed input drops the partial frame
            if (!i_pix_ready) begin
                row = 0;
                col = 0;
            end else begin
                seen_enable = 1'b1;
                if (i_pix_valid) begin
                    frame[row][col] = int'(i_pix);
                    if (row >= `CONV_K - 1 && col >= `CONV_K - 1) begin
                        exp_feat_q.push_back(model_window(row, col));
                        exp_due_q.push_back(cyc + OUT_DELAY);
                        exp_pos_q.push_back(row * `CONV_IMG_W + col);
                    end
                    // Raster advance, frames back to back
                    if (col == `CONV_IMG_W - 1) begin
                        col = 0;
                        row = (row == `CONV_IMG_H - 1) ? 0 : row + 1;
                    end else begin
                        col++;
                    end
                end
            end
            pending_cnt = exp_due_q.size();
        end
    end

    task automatic finish_report(input int ctrl_errors, input int exp_outputs);
        if (exp_due_q.size() != 0) begin
            err_cnt++;
            $display("Error: %0d expected outputs never appeared", exp_due_q.size());
        end
        if (checked_cnt != exp_outputs) begin
            err_cnt++;
            $display("Error: %0d outputs seen but the frames sent call for %0d",
                     checked_cnt, exp_outputs);
        end
        $display("Error counts: control %0d, data %0d, outputs checked %0d",
                 ctrl_errors, err_cnt, checked_cnt);
    endtask

endmodule

`default_nettype wire

/* dv/conv_tb.sv */
`default_nettype none

`include "conv_defs.svh"

module conv_tb;
    import conv_bus_pkg::*;
    import conv_data_pkg::*;

    localparam int NUM_FRAMES  = 4;
    localparam int FRAME_PIX   = `CONV_IMG_W * `CONV_IMG_H;
    localparam int WIN_PER_FRM = (`CONV_IMG_W - `CONV_K + 1) * (`CONV_IMG_H - `CONV_K + 1);
    // Four cycles per pixel plus room for bus traffic
    localparam int CYCLE_LIMIT = NUM_FRAMES * FRAME_PIX * 4 + 2000;

    // Region bases, region in address bits 7:6
    localparam logic [7:0] ADR_CTRL   = 8'h00;
    localparam logic [7:0] ADR_BIAS   = 8'h40;
    localparam logic [7:0] ADR_WEIGHT = 8'h80;

    logic      i_clk;
    logic      i_rst;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    logic      pix_valid;
    pixel_t    pix;
    logic      pix_ready;
    logic      feat_valid;
    feat_vec_t feat;

    integer seed;
    int     tb_err;
    int     cycle_cnt;
    // Values written, kept for readback
    int     wgt_val [`CONV_NUM_FILT][`CONV_TAPS];
    int     bias_val [`CONV_NUM_FILT];

    conv_top u_conv_top (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_wb         (wb_req),
        .o_wb         (wb_rsp),
        .i_pix_valid  (pix_valid),
        .i_pix        (pix),
        .o_pix_ready  (pix_ready),
        .o_feat_valid (feat_valid),
        .o_feat       (feat)
    );

    conv_checker u_checker (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_pix_valid  (pix_valid),
        .i_pix        (pix),
        .i_pix_ready  (pix_ready),
        .i_feat_valid (feat_valid),
        .i_feat       (feat)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // Hang guard
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Some tests failed");
        $finish;
    end

    //////////////////////////////////////////////////
    // Wishbone master
    //////////////////////////////////////////////////
    task automatic bus_write(input logic [7:0] adr, input logic [15:0] dat);
        @(posedge i_clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge i_clk);
        while (!wb_rsp.ack) begin
            @(negedge i_clk);
        end
        @(posedge i_clk);
        #1;
        wb_req = '0;
    endtask

    task automatic bus_read(input logic [7:0] adr, output logic [15:0] dat);
        @(posedge i_clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        @(negedge i_clk);
        while (!wb_rsp.ack) begin
            @(negedge i_clk);
        end
        dat = wb_rsp.dat;
        @(posedge i_clk);
        #1;
        wb_req = '0;
    endtask

    task automatic check_read(input logic [7:0] adr, input logic [15:0] expected);
        logic [15:0] got;
        bus_read(adr, got);
        if (got !== expected) begin
            tb_err++;
            $display("MISMATCH at time %0t: read of 0x%02h gave 0x%04h, expected 0x%04h",
                     $time, adr, got, expected);
        end
    endtask

    task automatic set_enable(input logic en);
        bus_write(ADR_CTRL, {15'd0, en});
        if (pix_ready !== en) begin
            tb_err++;
            $display("Error at time %0t: pixel ready is %b after enable was written as %b",
                     $time, pix_ready, en);
        end
        check_read(ADR_CTRL, {15'd0, en});
    endtask

    //////////////////////////////////////////////////
    // Coefficients
    //////////////////////////////////////////////////
    // Set 1 pins filter 0 at +127 and half of filter 1 at -128
    task automatic load_coefficients(input int set_idx);
        int w;
        int b;
        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                if (set_idx == 0) begin
                    w = ($random(seed) & 255) - 128;
                end else if (f == 0) begin
                    w = 127;
                end else if (t % 2 == 0) begin
                    w = -128;
                end else begin
                    w = ($random(seed) & 255) - 128;
                end
                wgt_val[f][t] = w;
                // Noise in the upper byte
                bus_write(8'(ADR_WEIGHT + f * `CONV_TAPS + t),
                          16'(($random(seed) & 32'hff00) | (w & 255)));
                u_checker.set_weight(f, t, w);
            end
        end
        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
            b = ($random(seed) & 32'hffff) - 32768;
            bias_val[f] = b;
            bus_write(8'(ADR_BIAS + f), 16'(b));
            u_checker.set_bias(f, b);
        end
    endtask

    task automatic verify_readback();
        // Write past the last bias is dropped
        bus_write(8'(ADR_BIAS + `CONV_NUM_FILT), 16'h5a5a);
        for (int f = 0; f < `CONV_NUM_FILT; f++) begin
            for (int t = 0; t < `CONV_TAPS; t++) begin
                check_read(8'(ADR_WEIGHT + f * `CONV_TAPS + t), 16'(wgt_val[f][t]));
            end
            check_read(8'(ADR_BIAS + f), 16'(bias_val[f]));
        end
        // Unmapped indexes read zero
        check_read(8'(ADR_BIAS + `CONV_NUM_FILT), 16'h0000);
        check_read(8'(ADR_WEIGHT + `CONV_NUM_FILT * `CONV_TAPS), 16'h0000);
        check_read(8'h01, 16'h0000);
        check_read(8'hc0, 16'h0000);
    endtask

    //////////////////////////////////////////////////
    // Pixel stream
    //////////////////////////////////////////////////
    task automatic idle_traffic(input int n);
        repeat (n) begin
            @(posedge i_clk);
            #1;
            pix_valid = ($random(seed) & 3) != 0;
            pix       = pixel_t'($random(seed));
        end
        @(posedge i_clk);
        #1;
        pix_valid = 1'b0;
    endtask

    // Valid on about three cycles in four
    task automatic stream_frames(input int nframes, input bit extreme);
        int sent;
        int pick;
        sent = 0;
        while (sent < nframes * FRAME_PIX) begin
            @(posedge i_clk);
            #1;
            pix_valid = ($random(seed) & 3) != 0;
            pick      = $random(seed) & 3;
            if (extreme && pick == 0) begin
                pix = '0;
            end else if (extreme && pick == 1) begin
                pix = '1;
            end else begin
                pix = pixel_t'($random(seed));
            end
            if (pix_valid) begin
                sent++;
            end
        end
        @(posedge i_clk);
        #1;
        pix_valid = 1'b0;
    endtask

    task automatic wait_drain();
        @(posedge i_clk);
        while (u_checker.pending_cnt != 0) begin
            @(posedge i_clk);
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////
    initial begin
        seed      = 32'hdf6d;
        tb_err    = 0;
        i_rst     = 1'b1;
        wb_req    = '0;
        pix_valid = 1'b0;
        pix       = '0;
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        @(negedge i_clk);
        if (pix_ready !== 1'b0) begin
            tb_err++;
            $display("Error at time %0t: pixel ready is high after reset", $time);
        end
        // Reset contents
        check_read(ADR_CTRL, 16'h0000);
        check_read(ADR_WEIGHT, 16'h0000);
        check_read(ADR_BIAS, 16'h0000);
        // Traffic before the first enable
        idle_traffic(30);
        // Two frames per coefficient set
        for (int s = 0; s < 2; s++) begin
            load_coefficients(s);
            verify_readback();
            set_enable(1'b1);
            stream_frames(NUM_FRAMES / 2, s == 1);
            set_enable(1'b0);
            wait_drain();
        end
        u_checker.finish_report(tb_err, NUM_FRAMES * WIN_PER_FRM);
        if (tb_err == 0 && u_checker.err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* conv_top.f */
+incdir+verilog
verilog/conv_data_pkg.sv
verilog/conv_bus_pkg.sv
verilog/conv_coef_regs.sv
verilog/conv_window_gen.sv
verilog/conv_mac_array.sv
verilog/conv_top.sv
dv/conv_sva.sv
dv/conv_checker.sv
dv/conv_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the conv_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_tb -f conv_top.f -o conv_sim

out=$(./obj_dir/conv_sim 2>&1 || true)
echo "$out"

# Pass only when the testbench printed its pass line
echo "$out" | grep -qx "All tests passed"
